// ==== build.f ====
+incdir+common
common/fetch_pkg.sv
fetch/branch_predictor.sv
fetch/dynamic_fetch.sv
fetch/pc_gen.sv
src/inst_queue.sv
src/fetch_top.sv
dv/fetch_props.sv
dv/fetch_tb.sv

// ==== dv/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam word_t B0 = `RESET_PC + 32'h40;  // slot 1 with its delay slot in the same pair
    localparam word_t B1 = `RESET_PC + 32'h9c;  // slot 2
    localparam word_t B2 = `RESET_PC + 32'ha4;  // alone in slot 1 after the B1 exit
    localparam word_t T0 = `RESET_PC;
    localparam word_t T1 = `RESET_PC + 32'h50;
    localparam int TAIL_LEN = 24;
    // 5 passes of B0 and 16 of B1 plus the tail at under 9 cycles per entry
    localparam int MAX_CYCLES = 9 * (5 * 17 + 16 * 21 + TAIL_LEN);

    logic         clk = 1'b0;
    logic         rst;
    word_t        pc;
    word_t        rsp_inst_1;
    word_t        rsp_inst_2;
    logic         rsp_ok_1;
    logic         rsp_ok_2;
    logic         icache_stall;
    ex_resolve_t  ex_res;
    fetch_entry_t out_entry;
    logic         out_valid;
    logic         out_ready;
    logic         flush_req;
    word_t        jmp_total;
    word_t        jmp_flush;

    int          errors = 0;
    int          cycles = 0;
    int          tail = 0;
    int          retired = 0;
    int          n_res = 0;
    int          n_flush = 0;
    int          res_cnt [3] = '{0, 0, 0};
    int          streak [3] = '{0, 0, 0};
    logic [15:0] lfsr = 16'd12;
    word_t       exp_pc = `RESET_PC;
    word_t       ds_next;
    logic        ds_due = 1'b0;     // next entry is a delay slot, then ds_next
    logic        res_due = 1'b0;
    logic        res_flush;
    logic        exp_flush = 1'b0;
    ex_resolve_t res_next;

    always #10 clk = ~clk;

    fetch_top fetch_top_i (
        .clk (clk), .rst (rst), .pc (pc),
        .rsp_inst_1 (rsp_inst_1), .rsp_inst_2 (rsp_inst_2),
        .rsp_ok_1 (rsp_ok_1), .rsp_ok_2 (rsp_ok_2), .icache_stall (icache_stall),
        .ex_res (ex_res), .out_entry (out_entry), .out_valid (out_valid),
        .out_ready (out_ready), .flush_req (flush_req),
        .jmp_total (jmp_total), .jmp_flush (jmp_flush)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic next_rand_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int branch_id(input word_t addr);
        if (addr == B0) return 0;
        if (addr == B1) return 1;
        if (addr == B2) return 2;
        return -1;
    endfunction

    function automatic word_t target_of(input int id);
        return (id == 0) ? T0 : T1;
    endfunction

    // scripted outcome of the n-th resolution of each branch
    function automatic logic script_taken(input int id, input int n);
        if (id == 0) return n < 4;
        if (id == 1) return (n % 4) != 3;   // inner loop of four
        return n < 3;
    endfunction

    function automatic word_t mem_word(input word_t addr);
        word_t off;
        if (branch_id(addr) >= 0) begin
            off = (target_of(branch_id(addr)) - addr - 32'd4) >> 2;
            return {`BEQ_OP, 10'd0, off[15:0]};
        end
        return {6'b001001, addr[27:2]};     // addiu is never a jump
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic take_entry(input fetch_entry_t e);
        int    id;
        logic  act;
        word_t tgt;
        word_t nxt;
        if (res_cnt[2] >= 4) tail++;
        retired++;
        check_word("out_entry.pc", e.pc, exp_pc);
        check_word("out_entry.inst", e.inst, mem_word(e.pc));
        id = branch_id(e.pc);
        if (id < 0) begin
            check_word("out_entry.pred_taken", e.pred_taken, 1'b0);
            exp_pc = ds_due ? ds_next : e.pc + 32'd4;
            ds_due = 1'b0;
        end else begin
            tgt = target_of(id);
            act = script_taken(id, res_cnt[id]);
            if (streak[id] >= 2) begin      // counter at least 2 and target buffer filled
                check_word("out_entry.pred_taken", e.pred_taken, 1'b1);
                check_word("out_entry.pred_target", e.pred_target, tgt);
            end
            res_cnt[id]++;
            streak[id] = act ? streak[id] + 1 : 0;
            nxt = act ? tgt : e.pc + 32'd8;
            res_next = '{valid: 1'b1, pc: e.pc, is_jmp: 1'b1, act_taken: act,
                         act_target: tgt, pred_taken: e.pred_taken,
                         pred_target: e.pred_target};
            res_flush = (act != e.pred_taken) || (act && (tgt != e.pred_target));
            res_due = 1'b1;
            exp_pc = res_flush ? nxt : e.pc + 32'd4;
            ds_due = !res_flush;
            ds_next = nxt;
        end
    endtask

    // one cycle of back end and memory at the falling edge
    task automatic step_cycle;
        check_word("flush_req", flush_req, exp_flush);
        check_word("jmp_total", jmp_total, n_res);
        check_word("jmp_flush", jmp_flush, n_flush);
        exp_flush = 1'b0;
        ex_res = '0;
        if (res_due) begin
            ex_res = res_next;
            exp_flush = res_flush;
            n_res++;
            n_flush += res_flush;
            res_due = 1'b0;
            out_ready = 1'b0;   // back end busy resolving
        end else begin
            out_ready = next_rand_bit();
            if (out_ready && out_valid) take_entry(out_entry);
        end
        icache_stall = next_rand_bit() & next_rand_bit();
        rsp_inst_1 = mem_word(pc);
        rsp_inst_2 = mem_word(pc + 32'd4);
        rsp_ok_2 = !pc[2];  // pair crosses the 8-byte block
    endtask

    task automatic end_run(input logic timed_out);
        int prop_fails;
        prop_fails = fetch_top_i.fetch_props_i.fails;
        $display("checks failed %0d, assertions failed %0d, entries %0d, jumps %0d, flushes %0d",
                 errors, prop_fails, retired, n_res, n_flush);
        if (errors == 0 && prop_fails == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    initial begin
        rst          = 1'b1;
        rsp_inst_1   = '0;
        rsp_inst_2   = '0;
        rsp_ok_1     = 1'b1;
        rsp_ok_2     = 1'b1;
        icache_stall = 1'b0;
        ex_res       = '0;
        out_ready    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_word("out_valid", out_valid, 1'b0);
        check_word("flush_req", flush_req, 1'b0);
        while (tail < TAIL_LEN && cycles < MAX_CYCLES) begin
            step_cycle();
            cycles++;
            @(negedge clk);
        end
        if (tail < TAIL_LEN) begin
            $display("timeout: program did not reach its end within %0d cycles", MAX_CYCLES);
        end
        end_run(tail < TAIL_LEN);
    end

endmodule

`default_nettype wire

// ==== dv/fetch_props.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_props (
    input wire                          clk,
    input wire                          rst,
    input wire fetch_pkg::word_t        pc,
    input wire                          pc_valid,
    input wire                          fetch_ena,
    input wire                          flush_req,
    input wire fetch_pkg::ex_resolve_t  ex_res,
    input wire                          out_valid,
    input wire                          out_ready,
    input wire fetch_pkg::fetch_entry_t out_entry,
    input wire                          queue_stall,
    input wire                          icache_stall,
    input wire [$clog2(`QUEUE_DEPTH):0] queue_count,
    input wire fetch_pkg::fetch_state_t state
);
    import fetch_pkg::*;

    int    fails = 0;
    word_t redirect;

    assign redirect = ex_res.act_taken ? ex_res.act_target : ex_res.pc + 32'd8;

    // quiet outputs and the reset address once reset is released
    a_reset: assert property (@(posedge clk)
        rst |=> !out_valid && !fetch_ena && !flush_req && (pc == `RESET_PC))
        else begin fails++; $error("outputs not idle after reset"); end

    a_redirect: assert property (@(posedge clk) disable iff (rst)
        flush_req |=> (pc == $past(redirect)) && !pc_valid)
        else begin fails++; $error("mispredict did not redirect pc"); end

    // never more entries than slots
    a_depth: assert property (@(posedge clk) disable iff (rst)
        queue_count <= `QUEUE_DEPTH)
        else begin fails++; $error("queue holds more entries than its depth"); end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (icache_stall || queue_stall) && !flush_req |=> $stable(pc) && $stable(state))
        else begin fails++; $error("pc or state moved during a stall"); end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush_req |=> out_valid && $stable(out_entry))
        else begin fails++; $error("queue head changed without a read"); end

endmodule

bind fetch_top fetch_props fetch_props_i (
    .clk (clk), .rst (rst), .pc (pc), .pc_valid (pc_valid),
    .fetch_ena (fetch_ena), .flush_req (flush_req), .ex_res (ex_res),
    .out_valid (out_valid), .out_ready (out_ready), .out_entry (out_entry),
    .queue_stall (queue_stall), .icache_stall (icache_stall),
    .queue_count (inst_queue_i.count), .state (dynamic_fetch_i.state)
);

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  wire                         clk,
    input  wire                         rst,
    output fetch_pkg::word_t            pc,
    input  wire fetch_pkg::word_t       rsp_inst_1,
    input  wire fetch_pkg::word_t       rsp_inst_2,
    input  wire                         rsp_ok_1,
    input  wire                         rsp_ok_2,
    input  wire                         icache_stall,
    input  wire fetch_pkg::ex_resolve_t ex_res,
    output fetch_pkg::fetch_entry_t     out_entry,
    output logic                        out_valid,
    input  wire                         out_ready,
    output logic                        flush_req,
    output fetch_pkg::word_t            jmp_total,
    output fetch_pkg::word_t            jmp_flush
);
    import fetch_pkg::*;

    logic         pc_valid;
    logic         fetch_ena;
    word_t        fetch_target;
    logic         fetch_stall;
    logic         queue_stall;
    logic         w_en_1;
    logic         w_en_2;
    logic         pred_taken_1;
    logic         pred_taken_2;
    word_t        pred_target_1;
    word_t        pred_target_2;
    fetch_entry_t w_entry_1;
    fetch_entry_t w_entry_2;

    assign fetch_stall = queue_stall | icache_stall;

    assign w_entry_1 = '{pc: pc, inst: rsp_inst_1,
                         pred_taken: pred_taken_1, pred_target: pred_target_1};
    assign w_entry_2 = '{pc: pc + 32'd4, inst: rsp_inst_2,
                         pred_taken: pred_taken_2, pred_target: pred_target_2};

    pc_gen pc_gen_i (
        .clk (clk), .rst (rst), .stall (fetch_stall), .flush_req (flush_req),
        .fetch_ena (fetch_ena), .fetch_target (fetch_target),
        .pc (pc), .pc_valid (pc_valid)
    );

    dynamic_fetch dynamic_fetch_i (
        .clk (clk), .rst (rst), .stall (icache_stall), .ex_res (ex_res),
        .pc_valid (pc_valid), .pc (pc),
        .rsp_inst_1 (rsp_inst_1), .rsp_inst_2 (rsp_inst_2),
        .rsp_ok_1 (rsp_ok_1), .rsp_ok_2 (rsp_ok_2), .queue_full (queue_stall),
        .fetch_ena (fetch_ena), .fetch_target (fetch_target), .flush_req (flush_req),
        .w_en_1 (w_en_1), .w_en_2 (w_en_2),
        .pred_taken_1 (pred_taken_1), .pred_taken_2 (pred_taken_2),
        .pred_target_1 (pred_target_1), .pred_target_2 (pred_target_2),
        .jmp_total (jmp_total), .jmp_flush (jmp_flush)
    );

    inst_queue inst_queue_i (
        .clk (clk), .rst (rst), .flush (flush_req),
        .w_en_1 (w_en_1), .w_en_2 (w_en_2),
        .w_entry_1 (w_entry_1), .w_entry_2 (w_entry_2),
        .out_entry (out_entry), .out_valid (out_valid), .out_ready (out_ready),
        .queue_stall (queue_stall)
    );

endmodule

`default_nettype wire

// ==== src/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module inst_queue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         flush,
    input  wire                         w_en_1,
    input  wire                         w_en_2,
    input  wire fetch_pkg::fetch_entry_t w_entry_1,
    input  wire fetch_pkg::fetch_entry_t w_entry_2,
    output fetch_pkg::fetch_entry_t     out_entry,
    output logic                        out_valid,
    input  wire                         out_ready,
    output logic                        queue_stall
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_entry_t     mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_wr;
    logic             rd;

    assign n_wr = {1'b0, w_en_1} + {1'b0, w_en_2};
    assign rd   = out_valid & out_ready;

    assign out_entry   = mem[rd_ptr];
    assign out_valid   = (count != '0);
    assign queue_stall = (count > CNT_W'(`QUEUE_DEPTH - 2));  // under two free

    // slot 2 packs behind slot 1, or takes the head if slot 1 is idle
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (w_en_1) begin
                mem[wr_ptr] <= w_entry_1;
            end
            if (w_en_2) begin
                mem[w_en_1 ? wr_ptr + 1'b1 : wr_ptr] <= w_entry_2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_wr);
            rd_ptr <= rd_ptr + PTR_W'(rd);
            count  <= count + CNT_W'(n_wr) - CNT_W'(rd);
        end
    end

endmodule

`default_nettype wire

// ==== fetch/pc_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module pc_gen (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stall,
    input  wire                     flush_req,
    input  wire                     fetch_ena,
    input  wire fetch_pkg::word_t   fetch_target,
    output fetch_pkg::word_t        pc,
    output logic                    pc_valid
);
    import fetch_pkg::*;

    word_t next_pair;

    // next 8-byte block with low bits cleared
    assign next_pair = {pc[31:3] + 29'd1, 3'b000};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `RESET_PC;
            pc_valid <= 1'b1;
        end else if (flush_req) begin   // mispredict wins over a stall
            pc       <= fetch_target;
            pc_valid <= 1'b0;
        end else if (!pc_valid) begin
            pc_valid <= 1'b1;           // one bubble after the flush while pc holds
        end else if (!stall) begin
            if (fetch_ena) begin
                pc <= fetch_target;
            end else begin
                pc <= next_pair;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetch/dynamic_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module dynamic_fetch (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    input  wire fetch_pkg::ex_resolve_t ex_res,
    input  wire                         pc_valid,
    input  wire fetch_pkg::word_t       pc,
    input  wire fetch_pkg::word_t       rsp_inst_1,
    input  wire fetch_pkg::word_t       rsp_inst_2,
    input  wire                         rsp_ok_1,
    input  wire                         rsp_ok_2,
    input  wire                         queue_full,
    output logic                        fetch_ena,
    output fetch_pkg::word_t            fetch_target,
    output logic                        flush_req,
    output logic                        w_en_1,
    output logic                        w_en_2,
    output logic                        pred_taken_1,
    output logic                        pred_taken_2,
    output fetch_pkg::word_t            pred_target_1,
    output fetch_pkg::word_t            pred_target_2,
    output fetch_pkg::word_t            jmp_total,
    output fetch_pkg::word_t            jmp_flush
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t next_state;

    word_t pc_plus4;
    word_t redirect_pc;
    word_t ds_target;       // target to remember while the delay slot is fetched
    word_t target_reg;
    logic  hold;
    logic  bp_taken_1;
    logic  bp_taken_2;
    logic  pred_dir_1;
    logic  pred_dir_2;

    function automatic logic is_jump(input word_t inst);
        case (inst[31:26])
            `BEQ_OP, `BNE_OP, `REGIMM_OP, `BGTZ_OP, `BLEZ_OP, `J_OP, `JAL_OP:
                return 1'b1;
            `SPECIAL_OP:
                return (inst[5:0] == `JR_FUNCT) || (inst[5:0] == `JALR_FUNCT);
            default:
                return 1'b0;
        endcase
    endfunction

    assign pc_plus4 = pc + 32'd4;
    assign hold     = stall | queue_full;

    branch_predictor branch_predictor_i (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .pc_plus4      (pc_plus4),
        .upd           (ex_res),
        .pred_taken_1  (bp_taken_1),
        .pred_taken_2  (bp_taken_2),
        .pred_target_1 (pred_target_1),
        .pred_target_2 (pred_target_2)
    );

    // predictor hit only counts on a real jump word
    assign pred_dir_1   = bp_taken_1 & is_jump(rsp_inst_1) & rsp_ok_1 & pc_valid;
    assign pred_dir_2   = bp_taken_2 & is_jump(rsp_inst_2) & rsp_ok_2 & pc_valid;
    assign pred_taken_1 = pred_dir_1;
    assign pred_taken_2 = pred_dir_2;

    // mispredict from execute
    assign flush_req = ex_res.valid && ex_res.is_jmp &&
                       ((ex_res.act_taken != ex_res.pred_taken) ||
                        (ex_res.act_taken && (ex_res.act_target != ex_res.pred_target)));
    assign redirect_pc = ex_res.act_taken ? ex_res.act_target : ex_res.pc + 32'd8;

    always_comb begin
        next_state   = NORMAL;
        fetch_ena    = 1'b0;
        fetch_target = '0;
        ds_target    = target_reg;
        case (state)
            FETCH_DS: begin
                fetch_ena    = 1'b1;
                fetch_target = target_reg;
                next_state   = FETCH_TARGET;
            end
            default: begin
                if (pred_dir_1 && rsp_ok_2) begin     // delay slot already in slot 2
                    fetch_ena    = 1'b1;
                    fetch_target = pred_target_1;
                end else if (pred_dir_1) begin
                    fetch_ena    = 1'b1;
                    fetch_target = pc_plus4;
                    ds_target    = pred_target_1;
                    next_state   = FETCH_DS;
                end else if (pred_dir_2) begin
                    fetch_ena    = 1'b1;
                    fetch_target = pc + 32'd8;
                    ds_target    = pred_target_2;
                    next_state   = FETCH_DS;
                end
            end
        endcase
        if (flush_req) begin
            fetch_ena    = 1'b1;
            fetch_target = redirect_pc;
            next_state   = NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_req) begin
            state <= NORMAL;
        end else if (!hold) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && next_state == FETCH_DS) begin
            target_reg <= ds_target;
        end
    end

    assign w_en_1 = pc_valid & rsp_ok_1 & ~hold;
    assign w_en_2 = pc_valid & rsp_ok_2 & ~hold & (state != FETCH_DS);  // past the delay slot

    // performance counters
    always_ff @(posedge clk) begin
        if (rst) begin
            jmp_total <= '0;
            jmp_flush <= '0;
        end else if (ex_res.valid && ex_res.is_jmp) begin
            jmp_total <= jmp_total + 32'd1;
            if (flush_req) begin
                jmp_flush <= jmp_flush + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== fetch/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_macros.svh"

module branch_predictor (
    input  wire                     clk,
    input  wire                     rst,
    input  wire fetch_pkg::word_t   pc,
    input  wire fetch_pkg::word_t   pc_plus4,
    input  wire fetch_pkg::ex_resolve_t upd,
    output logic                    pred_taken_1,
    output logic                    pred_taken_2,
    output fetch_pkg::word_t        pred_target_1,
    output fetch_pkg::word_t        pred_target_2
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`BHT_DEPTH);
    localparam int TAG_W = 32 - IDX_W - 2;

    cnt_t             bht        [`BHT_DEPTH];
    logic             btb_valid  [`BHT_DEPTH];
    logic [TAG_W-1:0] btb_tag    [`BHT_DEPTH];
    word_t            btb_target [`BHT_DEPTH];

    logic             upd_en;
    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;

    function automatic logic [IDX_W-1:0] index_of(input word_t addr);
        return addr[IDX_W+1:2];
    endfunction

    function automatic logic [TAG_W-1:0] tag_of(input word_t addr);
        return addr[31:IDX_W+2];
    endfunction

    // taken needs counter >= 2 and a target buffer hit
    function automatic logic predict(input word_t addr);
        logic [IDX_W-1:0] i;
        i = index_of(addr);
        return bht[i][1] && btb_valid[i] && (btb_tag[i] == tag_of(addr));
    endfunction

    always_comb begin
        pred_taken_1  = predict(pc);
        pred_taken_2  = predict(pc_plus4);
        pred_target_1 = btb_target[index_of(pc)];
        pred_target_2 = btb_target[index_of(pc_plus4)];
    end

    assign upd_en  = upd.valid && upd.is_jmp;
    assign upd_idx = index_of(upd.pc);
    assign upd_tag = tag_of(upd.pc);

    // counters and valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `BHT_DEPTH; i++) begin
                bht[i]       <= 2'b01;  // weakly not taken
                btb_valid[i] <= 1'b0;
            end
        end else if (upd_en) begin
            if (upd.act_taken) begin
                if (bht[upd_idx] != 2'b11) begin
                    bht[upd_idx] <= bht[upd_idx] + 1'b1;
                end
                btb_valid[upd_idx] <= 1'b1;
            end else if (bht[upd_idx] != 2'b00) begin
                bht[upd_idx] <= bht[upd_idx] - 1'b1;
            end
        end
    end

    // tag and target only change on a taken resolution
    always_ff @(posedge clk) begin
        if (upd_en && upd.act_taken) begin
            btb_tag[upd_idx]    <= upd_tag;
            btb_target[upd_idx] <= upd.act_target;
        end
    end

endmodule

`default_nettype wire

// ==== common/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // instruction or address word
    typedef logic [31:0] word_t;

    // 2-bit saturating direction counter
    typedef logic [1:0] cnt_t;

    // one branch resolution coming back from execute
    typedef struct packed {
        logic  valid;        // execute not stalled this cycle
        word_t pc;
        logic  is_jmp;
        logic  act_taken;
        word_t act_target;
        logic  pred_taken;   // prediction carried down the pipe
        word_t pred_target;
    } ex_resolve_t;

    // one entry of the instruction queue
    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  pred_taken;
        word_t pred_target;
    } fetch_entry_t;

    // delay-slot handling in the fetch controller
    typedef enum logic [1:0] {
        NORMAL,
        FETCH_DS,       // fetching the delay slot of a predicted branch
        FETCH_TARGET    // first pair at the predicted target
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== common/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// primary opcodes in inst[31:26]
`define BEQ_OP      6'b000100
`define BNE_OP      6'b000101
`define REGIMM_OP   6'b000001   // bltz/bgez and the linking forms
`define BGTZ_OP     6'b000111
`define BLEZ_OP     6'b000110
`define J_OP        6'b000010
`define JAL_OP      6'b000011
`define SPECIAL_OP  6'b000000

// funct codes under SPECIAL in inst[5:0]
`define JR_FUNCT    6'b001000
`define JALR_FUNCT  6'b001001

// predictor tables indexed by pc[7:2]
`define BHT_DEPTH   64

// instruction queue entries as a power of two
`define QUEUE_DEPTH 8

`define RESET_PC    32'hbfc0_0000

`endif
